//--- sim.f
+incdir+.
lsu_pkg.sv
lsu_req_gen.sv
lsu_resp_tracker.sv
lsu_rdata_align.sv
lsu_top.sv
tb_clkgen.sv
tb_lsu.sv

//--- tb_lsu.sv
/*
 * Random load/store regression against a byte-level reference memory.
 * The bus model aliases all addresses onto 64 words. Every wait has its own timeout.
 */

`include "lsu_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;

  logic                 clk;
  logic                 rst_n;
  logic                 valid_i;
  lsu_pkg::lsu_req_t    req_i;
  logic                 ready_o;
  logic                 data_req_o;
  lsu_pkg::bus_req_t    data_o;
  logic                 data_gnt_i;
  logic                 data_rvalid_i;
  logic [`LSU_XLEN-1:0] data_rdata_i;
  logic                 rdata_valid_o;
  logic [`LSU_XLEN-1:0] rdata_o;
  logic                 busy_o;
  logic                 protocol_err_o;

  // Bus side memory is written only through byte enables
  logic [`LSU_XLEN-1:0] bus_mem [64];
  // Reference memory holds one entry per byte address
  logic [7:0]           ref_mem [256];

  // Expected address phases and load results in issue order
  lsu_pkg::bus_req_t    exp_phase_q [$];
  logic [`LSU_XLEN-1:0] exp_rdata_q [$];
  // Pending bus responses and the cycle each becomes due
  logic [`LSU_XLEN-1:0] rsp_q [$];
  int                   due_q [$];

  int unsigned lcg_state = 89;
  string       test_name = "reset";
  int          err_cnt = 0;
  int          n_acc = 0;
  int          n_loads = 0;
  int          ready_cnt = 0;
  int          cycle = 0;
  int          gnt_pct = 100;
  bit          aborted = 1'b0;
  bit          stray_pend = 1'b0;
  bit          stray_active = 1'b0;
  int          stray_seen = 0;

  tb_clkgen clkgen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  lsu_top dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .req_i          (req_i),
    .ready_o        (ready_o),
    .data_req_o     (data_req_o),
    .data_o         (data_o),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_rdata_i   (data_rdata_i),
    .rdata_valid_o  (rdata_valid_o),
    .rdata_o        (rdata_o),
    .busy_o         (busy_o),
    .protocol_err_o (protocol_err_o)
  );

  ////////////////////////////////
  // Helpers
  ////////////////////////////////

  // LCG step returning the upper 16 state bits
  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] hi;
    hi = lcg_next();
    return (hi << 16) | lcg_next();
  endfunction

  // Initial contents differ for every byte address
  function automatic logic [7:0] init_byte(input int a);
    return 8'(a * 37 + 11);
  endfunction

  // Negative signed values sit one full range below the raw unsigned value
  function automatic logic [31:0] extend_load(input logic [31:0] raw, input logic [1:0] size,
                                              input logic sext);
    logic [31:0] res;
    case (size)
      `LSU_SIZE_BYTE: begin
        res = {24'h0, raw[7:0]};
        if (sext && raw[7]) res = res - 32'h100;
      end
      `LSU_SIZE_HALF: begin
        res = {16'h0, raw[15:0]};
        if (sext && raw[15]) res = res - 32'h10000;
      end
      default: begin
        res = raw;
      end
    endcase
    return res;
  endfunction

  task automatic report_mismatch(input string what, input logic [71:0] exp,
                                 input logic [71:0] act);
    $display("Mismatch test=%s field=%s expected=%0h actual=%0h", test_name, what, exp, act);
    err_cnt++;
  endtask

  task automatic report_error(input string msg);
    $display("Error in %s: %s", test_name, msg);
    err_cnt++;
  endtask

  ////////////////////////////////
  // Bus memory model
  ////////////////////////////////

  initial begin : bus_model
    lsu_pkg::bus_req_t exp_ph;
    lsu_pkg::bus_req_t held_req;
    bit                hold_pend;
    bit                gnt_now;
    bit                stray_go;
    int                lat;
    int                idx;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    hold_pend     = 1'b0;
    gnt_now       = 1'b0;
    stray_go      = 1'b0;
    for (int w = 0; w < 64; w++) begin
      for (int b = 0; b < 4; b++) begin
        bus_mem[w][8*b +: 8] = init_byte(4 * w + b);
      end
    end
    forever begin
      @(posedge clk);
      cycle++;
      gnt_now  = 1'b0;
      stray_go = 1'b0;
      if (!rst_n) begin
        hold_pend = 1'b0;
      end else begin
        // Response finished in the cycle just ended
        if (data_rvalid_i && stray_active) begin
          if (!protocol_err_o) report_error("protocol_err_o low on a stray response");
          stray_seen++;
        end else if (data_rvalid_i) begin
          void'(rsp_q.pop_front());
          void'(due_q.pop_front());
        end
        if (protocol_err_o && !(data_rvalid_i && stray_active)) begin
          report_error("protocol_err_o high without a stray response");
        end
        // Ungranted request must hold
        if (hold_pend) begin
          if (!data_req_o) report_error("data_req_o dropped before grant");
          else if (data_o !== held_req) report_mismatch("held data_o", held_req, data_o);
        end
        hold_pend = data_req_o && !data_gnt_i;
        held_req  = data_o;
        // Transfer
        if (data_req_o && data_gnt_i) begin
          if (exp_phase_q.size() == 0) begin
            report_error("bus transfer with no phase expected");
          end else begin
            exp_ph = exp_phase_q.pop_front();
            if (data_o.addr !== exp_ph.addr) report_mismatch("addr", exp_ph.addr, data_o.addr);
            if (data_o.we !== exp_ph.we) report_mismatch("we", exp_ph.we, data_o.we);
            if (data_o.be !== exp_ph.be) report_mismatch("be", exp_ph.be, data_o.be);
            if (data_o.wdata !== exp_ph.wdata) begin
              report_mismatch("wdata", exp_ph.wdata, data_o.wdata);
            end
          end
          idx = int'(data_o.addr[7:2]);
          if (data_o.we) begin
            for (int b = 0; b < 4; b++) begin
              if (data_o.be[b]) bus_mem[idx][8*b +: 8] = data_o.wdata[8*b +: 8];
            end
            rsp_q.push_back(rand_word());
          end else begin
            rsp_q.push_back(bus_mem[idx]);
          end
          // Latency 1 to 3 cycles after the grant
          lat = 1 + int'(lcg_next() % 3);
          due_q.push_back(cycle + lat - 1);
          if (rsp_q.size() > `LSU_DEPTH) report_error("more than LSU_DEPTH transfers outstanding");
        end
        gnt_now  = (lcg_next() % 100) < gnt_pct;
        stray_go = stray_pend && (rsp_q.size() == 0);
      end
      #2;
      data_gnt_i = gnt_now;
      if (stray_go) begin
        data_rvalid_i = 1'b1;
        data_rdata_i  = rand_word();
        stray_active  = 1'b1;
        stray_pend    = 1'b0;
      end else if (rsp_q.size() > 0 && due_q[0] <= cycle) begin
        data_rvalid_i = 1'b1;
        data_rdata_i  = rsp_q[0];
        stray_active  = 1'b0;
      end else begin
        data_rvalid_i = 1'b0;
        data_rdata_i  = '0;
        stray_active  = 1'b0;
      end
    end
  end

  ////////////////////////////////
  // Write-back monitor
  ////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      if (ready_o) ready_cnt++;
      if (rdata_valid_o) begin
        if (exp_rdata_q.size() == 0) begin
          report_error("rdata_valid_o with no load pending");
        end else begin
          if (rdata_o !== exp_rdata_q[0]) report_mismatch("rdata", exp_rdata_q[0], rdata_o);
          void'(exp_rdata_q.pop_front());
          n_loads++;
        end
      end
    end
  end

  ////////////////////////////////
  // Execute side stimulus
  ////////////////////////////////

  // Starts and returns 2 ns after a clock edge
  task automatic run_access(input logic we, input logic [1:0] size, input logic sext,
                            input logic [31:0] op_a, input logic [31:0] op_b,
                            input logic [31:0] wd);
    logic [31:0]       addr;
    logic [7:0]        lanes;
    logic [63:0]       dbl;
    logic [31:0]       raw;
    lsu_pkg::bus_req_t ph;
    int                nbytes;
    int                cyc;
    bit                done;
    addr   = op_a + op_b;
    nbytes = (size == `LSU_SIZE_BYTE) ? 1 : (size == `LSU_SIZE_HALF) ? 2 : 4;
    // Byte lanes over two adjacent words
    lanes  = (nbytes == 1) ? 8'h01 : (nbytes == 2) ? 8'h03 : 8'h0f;
    lanes  = lanes << addr[1:0];
    dbl    = {wd, wd} << (8 * addr[1:0]);
    ph.addr  = addr;
    ph.we    = we;
    ph.be    = lanes[3:0];
    ph.wdata = dbl[63:32];
    exp_phase_q.push_back(ph);
    // Crossing the word boundary adds a phase at the next word
    if (lanes[7:4] != 4'b0000) begin
      ph.addr = {addr[31:2], 2'b00} + 32'd4;
      ph.be   = lanes[7:4];
      exp_phase_q.push_back(ph);
    end
    if (we) begin
      for (int i = 0; i < nbytes; i++) ref_mem[(int'(addr[7:0]) + i) % 256] = wd[8*i +: 8];
    end else begin
      raw = '0;
      for (int i = 0; i < nbytes; i++) raw[8*i +: 8] = ref_mem[(int'(addr[7:0]) + i) % 256];
      exp_rdata_q.push_back(extend_load(raw, size, sext));
    end
    valid_i         = 1'b1;
    req_i.operand_a = op_a;
    req_i.operand_b = op_b;
    req_i.wdata     = wd;
    req_i.we        = we;
    req_i.size      = size;
    req_i.sext      = sext;
    n_acc++;
    done = 1'b0;
    for (cyc = 0; cyc < 200 && !done; cyc++) begin
      @(posedge clk);
      if (ready_o) done = 1'b1;
    end
    #2;
    if (!done) begin
      report_error($sformatf("timeout waiting for ready_o on access at %h", addr));
      aborted = 1'b1;
    end else if (exp_phase_q.size() != 0) begin
      report_error($sformatf("access at %h ended with a bus phase missing", addr));
      exp_phase_q.delete();
    end
    valid_i = 1'b0;
  endtask

  task automatic random_access(input bit misalign);
    logic        we;
    logic [1:0]  size;
    logic        sext;
    logic [1:0]  off;
    logic [31:0] target;
    logic [31:0] op_b;
    int unsigned r;
    int          gap;
    r    = lcg_next();
    we   = r[0];
    size = 2'((r >> 2) % 3);
    sext = r[8];
    off  = r[10:9];
    // Natural alignment unless misaligned accesses are wanted
    if (!misalign && size == `LSU_SIZE_HALF) off[0] = 1'b0;
    if (!misalign && size == `LSU_SIZE_WORD) off = 2'b00;
    target      = rand_word();
    target[1:0] = off;
    op_b        = rand_word();
    run_access(we, size, sext, target - op_b, op_b, rand_word());
    gap = int'(lcg_next() % 3);
    repeat (gap) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic run_phase(input string name, input int n, input int pct, input bit misalign);
    test_name = name;
    gnt_pct   = pct;
    for (int i = 0; i < n; i++) begin
      if (!aborted) random_access(misalign);
    end
  endtask

  // Waits for every response and an idle unit
  task automatic drain_and_check();
    bit idle;
    int cyc;
    if (aborted) return;
    test_name = "idle";
    idle      = 1'b0;
    for (cyc = 0; cyc < 100 && !idle; cyc++) begin
      @(posedge clk);
      #2;
      if (!busy_o && exp_rdata_q.size() == 0 && rsp_q.size() == 0) idle = 1'b1;
    end
    if (!idle) begin
      report_error("unit did not drain after the last access");
      aborted = 1'b1;
    end else if (data_req_o) begin
      report_error("data_req_o high while idle");
    end
  endtask

  // One response injected with nothing outstanding
  task automatic stray_check();
    bit seen;
    int cyc;
    if (aborted) return;
    test_name  = "protocol";
    stray_pend = 1'b1;
    seen       = 1'b0;
    for (cyc = 0; cyc < 20 && !seen; cyc++) begin
      @(posedge clk);
      #2;
      if (stray_seen > 0) seen = 1'b1;
    end
    if (!seen) begin
      report_error("stray response was never observed");
      aborted = 1'b1;
    end
  endtask

  initial begin : main_seq
    bit rst_seen;
    int cyc;
    valid_i = 1'b0;
    req_i   = '0;
    for (int a = 0; a < 256; a++) ref_mem[a] = init_byte(a);
    rst_seen = 1'b0;
    for (cyc = 0; cyc < 40 && !rst_seen; cyc++) begin
      @(posedge clk);
      if (rst_n) rst_seen = 1'b1;
    end
    if (!rst_seen) begin
      report_error("reset never released");
      aborted = 1'b1;
    end else if (busy_o || data_req_o || ready_o || rdata_valid_o || protocol_err_o) begin
      report_error("outputs not low after reset");
    end
    #2;
    run_phase("aligned", 60, 90, 1'b0);
    run_phase("misaligned", 80, 80, 1'b1);
    run_phase("backpressure", 60, 25, 1'b1);
    drain_and_check();
    stray_check();
    if (!aborted && ready_cnt != n_acc) begin
      report_error($sformatf("%0d ready_o pulses for %0d accesses", ready_cnt, n_acc));
    end
    $display("Summary: %0d errors, %0d accesses, %0d loads checked", err_cnt, n_acc, n_loads);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_clkgen.sv
/*
 * Testbench clock and reset source. 40 ns period.
 * Reset is held low for 16 rising edges and released 2 ns after the last one.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam time HALF_PERIOD = 20ns;
  localparam int  RST_CYCLES  = 16;

  // Free running clock
  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Release away from the edge, like the other inputs
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- lsu_top.sv
/*
 * Load/store unit top. Responses must return in order, at least a cycle after grant.
 * Write-back always accepts rdata_o in the rdata_valid_o cycle.
 */

`include "lsu_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  wire logic                 clk,
  input  wire logic                 rst_n,

  // Execute stage
  input  wire logic                 valid_i,
  input  wire lsu_pkg::lsu_req_t    req_i,
  output logic                      ready_o,

  // Data bus
  output logic                      data_req_o,
  output lsu_pkg::bus_req_t         data_o,
  input  wire logic                 data_gnt_i,
  input  wire logic                 data_rvalid_i,
  input  wire logic [`LSU_XLEN-1:0] data_rdata_i,

  // Write-back
  output logic                      rdata_valid_o,
  output logic [`LSU_XLEN-1:0]      rdata_o,

  // Status
  output logic                      busy_o,
  output logic                      protocol_err_o
);

  lsu_pkg::wb_ctrl_t wb_ctrl;
  lsu_pkg::wb_ctrl_t wb_head;
  logic              trk_full;
  logic              trk_empty;
  logic              split_active;
  logic              bus_xfer;
  logic              rsp_valid;

  ////////////////////////////////
  // Request side
  ////////////////////////////////

  lsu_req_gen req_gen_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .req_i          (req_i),
    .full_i         (trk_full),
    .gnt_i          (data_gnt_i),
    .data_req_o     (data_req_o),
    .bus_req_o      (data_o),
    .wb_ctrl_o      (wb_ctrl),
    .split_active_o (split_active),
    .ready_o        (ready_o)
  );

  // Accepted address phase
  assign bus_xfer = data_req_o && data_gnt_i;

  ////////////////////////////////
  // Outstanding transfers
  ////////////////////////////////

  lsu_resp_tracker resp_tracker_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .push_i         (bus_xfer),
    .push_data_i    (wb_ctrl),
    .pop_i          (data_rvalid_i),
    .head_o         (wb_head),
    .full_o         (trk_full),
    .empty_o        (trk_empty),
    .protocol_err_o (protocol_err_o)
  );

  // Stray responses carry no valid head entry
  assign rsp_valid = data_rvalid_i && !trk_empty;

  ////////////////////////////////
  // Response side
  ////////////////////////////////

  lsu_rdata_align rdata_align_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .rvalid_i      (rsp_valid),
    .rdata_i       (data_rdata_i),
    .head_i        (wb_head),
    .rdata_valid_o (rdata_valid_o),
    .rdata_o       (rdata_o)
  );

  // Requesting, mid split, or waiting on responses
  assign busy_o = data_req_o || split_active || !trk_empty;

endmodule

`default_nettype wire

//--- lsu_rdata_align.sv
/*
 * Read data realignment and extension. head_i must describe the response in rvalid_i.
 * Store responses and first phases never raise rdata_valid_o.
 */

`include "lsu_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module lsu_rdata_align (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 rvalid_i,
  input  wire logic [`LSU_XLEN-1:0] rdata_i,
  input  wire lsu_pkg::wb_ctrl_t    head_i,
  output logic                      rdata_valid_o,
  output logic [`LSU_XLEN-1:0]      rdata_o
);

  // Raw first-phase word of a split load
  logic [`LSU_XLEN-1:0]   rdata_q;
  logic                   load_rsp;
  logic                   first_rsp;
  logic                   is_split;
  logic [2*`LSU_XLEN-1:0] rdata_full;
  logic [`LSU_XLEN-1:0]   rdata_word;

  assign load_rsp  = rvalid_i && !head_i.we;
  assign first_rsp = load_rsp && !head_i.last;

  ////////////////////////////////
  // First phase capture
  ////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (first_rsp) begin
      rdata_q <= rdata_i;
    end
  end

  ////////////////////////////////
  // Realignment
  ////////////////////////////////

  // Same split rule as the request side
  assign is_split = ((head_i.size == `LSU_SIZE_WORD) && (head_i.offset != 2'b00)) ||
                    ((head_i.size == `LSU_SIZE_HALF) && (head_i.offset == 2'b11));

  // Split: low bytes from the earlier word
  // Otherwise the doubled word lets the shift wrap the upper lanes down
  assign rdata_full = is_split ? {rdata_i, rdata_q} : {rdata_i, rdata_i};

  // Shift right by 8 * offset, keep the low word
  assign rdata_word = `LSU_XLEN'(rdata_full >> {head_i.offset, 3'b000});

  // Sign or zero extension
  always_comb begin
    case (head_i.size)
      `LSU_SIZE_BYTE: begin
        rdata_o = {{24{head_i.sext && rdata_word[7]}}, rdata_word[7:0]};
      end
      `LSU_SIZE_HALF: begin
        rdata_o = {{16{head_i.sext && rdata_word[15]}}, rdata_word[15:0]};
      end
      default: begin
        rdata_o = rdata_word;
      end
    endcase
  end

  // End of a load, one pulse per access
  assign rdata_valid_o = load_rsp && head_i.last;

endmodule

`default_nettype wire

//--- lsu_resp_tracker.sv
/*
 * In-order queue of write-back info, one entry per outstanding bus transfer.
 * Depth is LSU_DEPTH. Pops while empty are dropped and flagged.
 */

`include "lsu_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module lsu_resp_tracker (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               push_i,
  input  wire lsu_pkg::wb_ctrl_t  push_data_i,
  input  wire logic               pop_i,
  output lsu_pkg::wb_ctrl_t       head_o,
  output logic                    full_o,
  output logic                    empty_o,
  output logic                    protocol_err_o
);

  localparam int PTR_W = (`LSU_DEPTH > 1) ? $clog2(`LSU_DEPTH) : 1;

  lsu_pkg::wb_ctrl_t     fifo_q [`LSU_DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [`LSU_CNT_W-1:0] cnt_q;
  logic [`LSU_CNT_W-1:0] cnt_d;
  logic                  do_push;
  logic                  do_pop;

  // Circular pointer advance
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(`LSU_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign full_o  = (cnt_q == `LSU_CNT_W'(`LSU_DEPTH));
  assign empty_o = (cnt_q == '0);

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Response with nothing outstanding
  assign protocol_err_o = pop_i && empty_o;

  ////////////////////////////////
  // Occupancy
  ////////////////////////////////

  always_comb begin
    case ({do_push, do_pop})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      // Push and pop together leave the count
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q    <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      cnt_q <= cnt_d;
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
    end
  end

  ////////////////////////////////
  // Storage
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (do_push) begin
      fifo_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Oldest outstanding transfer
  assign head_o = fifo_q[rd_ptr_q];

  // Request side must hold off while every slot is taken
  a_no_push_full : assert property (@(posedge clk) disable iff (!rst_n)
    !(push_i && full_o));

endmodule

`default_nettype wire

//--- lsu_req_gen.sv
/*
 * Address phase generation. Expects valid_i and req_i held until ready_o.
 * A split access issues its second phase no earlier than the cycle after the first grant.
 */

`include "lsu_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module lsu_req_gen (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               valid_i,
  input  wire lsu_pkg::lsu_req_t  req_i,
  input  wire logic               full_i,
  input  wire logic               gnt_i,
  output logic                    data_req_o,
  output lsu_pkg::bus_req_t       bus_req_o,
  output lsu_pkg::wb_ctrl_t       wb_ctrl_o,
  output logic                    split_active_o,
  output logic                    ready_o
);

  logic [`LSU_XLEN-1:0] addr;
  logic [1:0]           offset;
  // Second phase of a split access in progress
  logic                 split_q;
  // First phase of an access that needs two transfers
  logic                 split_first;
  logic                 xfer;
  logic [`LSU_BE_W-1:0] be;
  logic [`LSU_XLEN-1:0] wdata_rot;

  // Effective address
  assign addr   = req_i.operand_a + req_i.operand_b;
  assign offset = addr[1:0];

  // Misaligned word, or halfword crossing the word boundary
  always_comb begin
    split_first = 1'b0;
    if (valid_i && !split_q) begin
      case (req_i.size)
        `LSU_SIZE_BYTE: split_first = 1'b0;
        `LSU_SIZE_HALF: split_first = (offset == 2'b11);
        default:        split_first = (offset != 2'b00);
      endcase
    end
  end

  ////////////////////////////////
  // Handshake
  ////////////////////////////////

  // No request while the tracker has no free slot
  assign data_req_o = valid_i && !full_i;
  assign xfer       = data_req_o && gnt_i;

  // Execute stage released on the grant of the last phase
  assign ready_o = xfer && !split_first;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!valid_i) begin
      // Killed or idle, next access starts on its first phase
      split_q <= 1'b0;
    end else if (xfer) begin
      split_q <= split_first;
    end
  end

  assign split_active_o = split_q;

  ////////////////////////////////
  // Byte enables
  ////////////////////////////////

  always_comb begin
    be = 4'b0000;
    case (req_i.size)
      `LSU_SIZE_BYTE: begin
        case (offset)
          2'b00:   be = 4'b0001;
          2'b01:   be = 4'b0010;
          2'b10:   be = 4'b0100;
          default: be = 4'b1000;
        endcase
      end
      `LSU_SIZE_HALF: begin
        if (!split_q) begin
          case (offset)
            2'b00:   be = 4'b0011;
            2'b01:   be = 4'b0110;
            2'b10:   be = 4'b1100;
            default: be = 4'b1000;
          endcase
        end else begin
          // Upper byte lands in lane 0 of the next word
          be = 4'b0001;
        end
      end
      default: begin
        if (!split_q) begin
          case (offset)
            2'b00:   be = 4'b1111;
            2'b01:   be = 4'b1110;
            2'b10:   be = 4'b1100;
            default: be = 4'b1000;
          endcase
        end else begin
          // Offset 0 never splits
          case (offset)
            2'b00:   be = 4'b0000;
            2'b01:   be = 4'b0001;
            2'b10:   be = 4'b0011;
            default: be = 4'b0111;
          endcase
        end
      end
    endcase
  end

  // Rotate left by 8 * offset, same lanes for both phases
  always_comb begin
    case (offset)
      2'b00:   wdata_rot = req_i.wdata;
      2'b01:   wdata_rot = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'b10:   wdata_rot = {req_i.wdata[15:0], req_i.wdata[31:16]};
      default: wdata_rot = {req_i.wdata[7:0], req_i.wdata[31:8]};
    endcase
  end

  ////////////////////////////////
  // Phase outputs
  ////////////////////////////////

  always_comb begin
    // Second phase goes to the next aligned word
    bus_req_o.addr  = split_q ? ({addr[`LSU_XLEN-1:2], 2'b00} + `LSU_XLEN'(4)) : addr;
    bus_req_o.we    = req_i.we;
    bus_req_o.be    = be;
    bus_req_o.wdata = wdata_rot;

    wb_ctrl_o.size   = req_i.size;
    wb_ctrl_o.sext   = req_i.sext;
    wb_ctrl_o.offset = offset;
    wb_ctrl_o.we     = req_i.we;
    wb_ctrl_o.last   = !split_first;
  end

  // Relies on the core holding req_i and on full_i only rising after a grant
  a_bus_req_stable : assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o && !gnt_i |=> data_req_o && $stable(bus_req_o));

endmodule

`default_nettype wire

//--- lsu_pkg.sv
/*
 * Struct types shared by the load/store unit and its data bus.
 * Field widths come from the defines header.
 */

`include "lsu_defines.svh"
`default_nettype none

package lsu_pkg;

  ////////////////////////////////
  // Execute stage request
  ////////////////////////////////

  // Held stable by the core until ready
  typedef struct packed {
    logic [`LSU_XLEN-1:0] operand_a;
    logic [`LSU_XLEN-1:0] operand_b;
    // Store data, unrotated
    logic [`LSU_XLEN-1:0] wdata;
    logic                 we;
    logic [1:0]           size;
    // Sign extend loaded byte or halfword
    logic                 sext;
  } lsu_req_t;

  ////////////////////////////////
  // Data bus address phase
  ////////////////////////////////

  typedef struct packed {
    logic [`LSU_XLEN-1:0] addr;
    logic                 we;
    logic [`LSU_BE_W-1:0] be;
    // Already rotated onto byte lanes
    logic [`LSU_XLEN-1:0] wdata;
  } bus_req_t;

  ////////////////////////////////
  // Per transaction write-back info
  ////////////////////////////////

  typedef struct packed {
    logic [1:0] size;
    logic       sext;
    // Byte offset of the original access address
    logic [1:0] offset;
    logic       we;
    // Low only for the first phase of a split access
    logic       last;
  } wb_ctrl_t;

endpackage

`default_nettype wire

//--- lsu_defines.svh
/*
 * Global sizing for the load/store unit. LSU_CNT_W must hold 0 to LSU_DEPTH.
 * Size codes follow the core encoding. Code 3 is treated as a word access.
 */

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Data and address width
`define LSU_XLEN 32

// Byte enable width, one bit per byte lane
`define LSU_BE_W (`LSU_XLEN / 8)

// Maximum outstanding bus transactions
`define LSU_DEPTH 2

// Counter width for 0..LSU_DEPTH
`define LSU_CNT_W $clog2(`LSU_DEPTH + 1)

// Access size codes
`define LSU_SIZE_BYTE 2'd0
`define LSU_SIZE_HALF 2'd1
`define LSU_SIZE_WORD 2'd2

`endif
